// ==== logic/objEngine_defines.svh ====
// Size and count constants of the sprite engine
// Included by the package and by every module that sizes an array or a counter

`ifndef OBJ_ENGINE_DEFINES_SVH
`define OBJ_ENGINE_DEFINES_SVH

// Sprite attribute table
`define OBJ_COUNT     128  // Entries in the table
`define OBJ_BYTES     4    // Bytes per entry
`define OBJ_RAM_AW    9    // Attribute byte address width

// Display line
`define LINE_PIXELS   256  // Pixels per line buffer

// Graphics ROM layout
`define TILE_ROWS     16   // Rows in one tile
`define TILE_WORDS    4    // ROM words per tile row
`define PIX_PER_WORD  4    // 4-bit pixels packed per word
`define ROM_AW        17   // ROM word address width

`endif

// ==== logic/objPkg.sv ====
// Shared types of the sprite engine
// Widths with a meaning get their own typedef, FSM states their own enum

`include "objEngine_defines.svh"

package objPkg;

	// CPU side
	typedef logic [`OBJ_RAM_AW-1:0] cpuAddrT;  // Attribute byte address
	typedef logic [7:0]             byteT;

	// Sprite attributes
	typedef logic [10:0] tileNumT;   // {byte1[2:0], byte2}
	typedef logic [2:0]  paletteT;
	typedef logic [3:0]  colorT;     // 0 is transparent
	typedef logic [6:0]  objPixT;    // {palette, color}
	typedef logic [7:0]  xPosT;
	typedef logic [7:0]  lineT;
	typedef logic [$clog2(`TILE_ROWS)-1:0] tileRowT;

	// Graphics ROM
	typedef logic [`ROM_AW-1:0]         romAddrT;  // {tile, word column, row}
	typedef logic [`PIX_PER_WORD*4-1:0] romWordT;  // First pixel in the top nibble

	// ----------------------------------------
	// FSM states
	// ----------------------------------------
	typedef enum logic [1:0] {
		scanIdle,   // Waiting for lineStart
		scanRead,   // Reading the four bytes of an entry
		scanCheck,  // Vertical hit test
		scanWait    // Hit handed over, fetcher busy
	} scanStateT;

	typedef enum logic [1:0] {
		fetchIdle,     // Waiting for a hit
		fetchRequest,  // romReq held until romRdy
		fetchWrite     // Four pixels of the latched word
	} fetchStateT;

endpackage

// ==== logic/objSpriteRam.sv ====
// Sprite attribute RAM, 128 entries of 4 bytes
// CPU port for reads and writes, separate read port for the line scanner

`timescale 1ns/1ps
`include "objEngine_defines.svh"

module objSpriteRam (
	input  logic            clk,
	input  logic            cpuSel,
	input  logic            cpuWe,
	input  objPkg::cpuAddrT cpuAddr,
	input  objPkg::byteT    cpuWrData,
	output objPkg::byteT    cpuRdData,
	input  objPkg::cpuAddrT scanAddr,
	output objPkg::byteT    scanData
);
	import objPkg::*;

	localparam int DEPTH = `OBJ_COUNT * `OBJ_BYTES;

	byteT mem [DEPTH];  // Y, attributes, tile low, X per entry

	logic cpuRead;

	assign cpuRead = cpuSel && !cpuWe;

	// ----------------------------------------
	// CPU port
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (cpuSel && cpuWe) begin
			mem[cpuAddr] <= cpuWrData;
		end
		// Idle bus reads back as FF
		cpuRdData <= cpuRead ? mem[cpuAddr] : 8'hFF;
	end

	// Scan port, one cycle latency
	always_ff @(posedge clk) begin
		scanData <= mem[scanAddr];
	end

endmodule

// ==== logic/objLineScanner.sv ====
// Per-line walk over the sprite table
// Reads each entry, runs the vertical test and hands visible sprites to the fetcher

`timescale 1ns/1ps
`include "objEngine_defines.svh"

module objLineScanner (
	input  logic            clk,
	input  logic            rstN,
	input  logic            lineStart,
	input  objPkg::lineT    lineNum,
	output objPkg::cpuAddrT scanAddr,
	input  objPkg::byteT    scanData,
	input  logic            fetchBusy,
	output logic            hitValid,
	output objPkg::tileNumT hitTile,
	output objPkg::tileRowT hitRow,
	output objPkg::paletteT hitPalette,
	output logic            hitFlip,
	output objPkg::xPosT    hitX,
	output logic            scanBusy
);
	import objPkg::*;

	localparam int ENTRY_W = $clog2(`OBJ_COUNT);
	localparam int BYTE_W  = $clog2(`OBJ_BYTES);

	scanStateT          state;
	logic [ENTRY_W-1:0] entry;      // Table index
	logic [BYTE_W:0]    byteCnt;    // Extra bit for the trailing capture
	logic [BYTE_W-1:0]  capSel;     // Byte arriving on scanData
	lineT               lineReg;
	byteT               yReg;
	byteT               attrReg;
	byteT               tileLoReg;
	xPosT               xReg;
	lineT               row;
	logic               dblH;
	logic               onLine;
	logic               lastEntry;
	tileNumT            tile;

	assign scanAddr  = {entry, byteCnt[BYTE_W-1:0]};
	assign scanBusy  = (state != scanIdle);  // Covers the fetcher through scanWait
	assign capSel    = byteCnt[BYTE_W-1:0] - 1'b1;
	assign lastEntry = (entry == ENTRY_W'(`OBJ_COUNT - 1));

	// ----------------------------------------
	// Vertical test and tile select
	// ----------------------------------------
	assign row    = lineReg - yReg;  // Wraps mod 256
	assign dblH   = attrReg[7];
	assign onLine = dblH ? (row < lineT'(2 * `TILE_ROWS)) : (row < lineT'(`TILE_ROWS));
	// Double height picks the lower tile of the pair by row bit 4
	assign tile   = {attrReg[2:0], tileLoReg[7:1], dblH ? row[4] : tileLoReg[0]};

	// Entry bytes and hit payload
	always_ff @(posedge clk) begin
		if (lineStart) begin
			lineReg <= lineNum;
		end
		if (state == scanRead && byteCnt != '0) begin
			case (capSel)
				2'd0:    yReg      <= scanData;
				2'd1:    attrReg   <= scanData;
				2'd2:    tileLoReg <= scanData;
				default: xReg      <= scanData;
			endcase
		end
		if (state == scanCheck && onLine) begin
			hitTile    <= tile;
			hitRow     <= tileRowT'(row);
			hitPalette <= attrReg[5:3];
			hitFlip    <= attrReg[6];
			hitX       <= xReg;
		end
	end

	// ----------------------------------------
	// Scan FSM
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state    <= scanIdle;
			entry    <= '0;
			byteCnt  <= '0;
			hitValid <= 1'b0;
		end else begin
			hitValid <= 1'b0;  // One-cycle pulse
			unique case (state)
				scanIdle: begin
					if (lineStart) begin
						entry   <= '0;
						byteCnt <= '0;
						state   <= scanRead;
					end
				end
				scanRead: begin
					// Last byte lands one cycle after its address
					if (byteCnt == (BYTE_W + 1)'(`OBJ_BYTES)) state <= scanCheck;
					else byteCnt <= byteCnt + 1'b1;
				end
				scanCheck: begin
					byteCnt <= '0;
					if (onLine) begin
						hitValid <= 1'b1;
						state    <= scanWait;
					end else if (lastEntry) begin
						state <= scanIdle;
					end else begin
						entry <= entry + 1'b1;
						state <= scanRead;
					end
				end
				scanWait: begin
					if (!fetchBusy) begin  // Last pixel of this sprite written
						if (lastEntry) begin
							state <= scanIdle;
						end else begin
							entry <= entry + 1'b1;
							state <= scanRead;
						end
					end
				end
				default: state <= scanIdle;
			endcase
		end
	end

endmodule

// ==== logic/objTileFetcher.sv ====
// Tile row fetch and pixel writer
// Reads the four ROM words of a sprite row and writes its opaque pixels to the line buffer

`timescale 1ns/1ps
`include "objEngine_defines.svh"

module objTileFetcher (
	input  logic            clk,
	input  logic            rstN,
	input  logic            hitValid,
	input  objPkg::tileNumT hitTile,
	input  objPkg::tileRowT hitRow,
	input  objPkg::paletteT hitPalette,
	input  logic            hitFlip,
	input  objPkg::xPosT    hitX,
	output logic            fetchBusy,
	output logic            romReq,
	output objPkg::romAddrT romAddr,
	input  logic            romRdy,
	input  objPkg::romWordT romData,
	output logic            wrEn,
	output objPkg::xPosT    wrX,
	output objPkg::objPixT  wrPix
);
	import objPkg::*;

	localparam int WORD_W = $clog2(`TILE_WORDS);
	localparam int PIX_W  = $clog2(`PIX_PER_WORD);
	localparam int COL_W  = WORD_W + PIX_W;

	fetchStateT        state;
	tileNumT           tileReg;
	tileRowT           rowReg;
	paletteT           palReg;
	logic              flipReg;
	xPosT              xReg;
	romWordT           wordReg;
	logic [WORD_W-1:0] wordCnt;  // Word column in the row
	logic [PIX_W-1:0]  pixCnt;   // Pixel in the word
	logic [COL_W-1:0]  col;      // Tile column 0..15
	logic [COL_W-1:0]  offset;   // Screen offset from X
	colorT             color;

	assign romAddr   = {tileReg, wordCnt, rowReg};
	assign fetchBusy = hitValid | (state != fetchIdle) | wrEn;  // Until the last write

	// Pixel 0 sits in the top nibble
	assign color  = wordReg[(`PIX_PER_WORD - 1 - pixCnt) * $bits(colorT) +: $bits(colorT)];
	assign col    = {wordCnt, pixCnt};
	assign offset = flipReg ? ~col : col;  // 15 - c under flip

	// ----------------------------------------
	// Payload registers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (state == fetchIdle && hitValid) begin
			tileReg <= hitTile;
			rowReg  <= hitRow;
			palReg  <= hitPalette;
			flipReg <= hitFlip;
			xReg    <= hitX;
		end
		if (state == fetchRequest && romRdy) wordReg <= romData;
		if (state == fetchWrite) begin
			wrX   <= xReg + xPosT'(offset);  // Wraps at 256
			wrPix <= {palReg, color};
		end
	end

	// Fetch FSM
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state   <= fetchIdle;
			romReq  <= 1'b0;
			wordCnt <= '0;
			pixCnt  <= '0;
			wrEn    <= 1'b0;
		end else begin
			wrEn <= 1'b0;
			unique case (state)
				fetchIdle: begin
					if (hitValid) begin
						wordCnt <= '0;
						romReq  <= 1'b1;
						state   <= fetchRequest;
					end
				end
				fetchRequest: begin
					if (romRdy) begin  // Address held stable until here
						romReq <= 1'b0;
						pixCnt <= '0;
						state  <= fetchWrite;
					end
				end
				fetchWrite: begin
					wrEn   <= (color != '0);  // Transparent pixels skipped
					pixCnt <= pixCnt + 1'b1;
					if (pixCnt == PIX_W'(`PIX_PER_WORD - 1)) begin
						if (wordCnt == WORD_W'(`TILE_WORDS - 1)) begin
							state <= fetchIdle;
						end else begin
							wordCnt <= wordCnt + 1'b1;
							romReq  <= 1'b1;
							state   <= fetchRequest;
						end
					end
				end
				default: state <= fetchIdle;
			endcase
		end
	end

endmodule

// ==== logic/objLineBuffer.sv ====
// Double-buffered sprite line store
// One bank takes fetcher writes while the other is shown at hPos and cleared behind the read

`timescale 1ns/1ps
`include "objEngine_defines.svh"

module objLineBuffer (
	input  logic           clk,
	input  logic           rstN,
	input  logic           lineStart,
	input  logic           wrEn,
	input  objPkg::xPosT   wrX,
	input  objPkg::objPixT wrPix,
	input  objPkg::xPosT   hPos,
	output objPkg::objPixT pixOut
);
	import objPkg::*;

	logic   dispSel;     // Bank on display, the other is written
	objPixT bankRd [2];  // Each bank at hPos

	// ----------------------------------------
	// Banks
	// ----------------------------------------
	for (genvar b = 0; b < 2; b++) begin : genBank
		objPixT mem [`LINE_PIXELS];

		always_ff @(posedge clk) begin
			if (dispSel == 1'(b)) begin
				mem[hPos] <= '0;  // Clear behind the display read
			end else if (wrEn) begin
				mem[wrX] <= wrPix;
			end
		end

		assign bankRd[b] = mem[hPos];
	end

	// ----------------------------------------
	// Bank select and display output
	// ----------------------------------------
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			dispSel <= 1'b0;
			pixOut  <= '0;
		end else begin
			if (lineStart) dispSel <= ~dispSel;  // Swap once per line
			pixOut <= bankRd[dispSel];           // Old value of the cleared location
		end
	end

endmodule

// ==== logic/objEngine.sv ====
// Sprite engine top level
// Attribute RAM, line scanner, tile fetcher and line buffer on one clock

`timescale 1ns/1ps

module objEngine (
	input  logic            clk,
	input  logic            rstN,
	// CPU port
	input  logic            cpuSel,
	input  logic            cpuWe,
	input  objPkg::cpuAddrT cpuAddr,
	input  objPkg::byteT    cpuWrData,
	output objPkg::byteT    cpuRdData,
	// Line control
	input  logic            lineStart,
	input  objPkg::lineT    lineNum,
	output logic            lineBusy,
	// Display
	input  objPkg::xPosT    hPos,
	output objPkg::objPixT  pixOut,
	// Graphics ROM
	output logic            romReq,
	output objPkg::romAddrT romAddr,
	input  logic            romRdy,
	input  objPkg::romWordT romData
);
	import objPkg::*;

	// ----------------------------------------
	// Internal wires
	// ----------------------------------------
	cpuAddrT scanAddr;
	byteT    scanData;
	logic    fetchBusy;
	logic    hitValid;
	tileNumT hitTile;
	tileRowT hitRow;
	paletteT hitPalette;
	logic    hitFlip;
	xPosT    hitX;
	logic    wrEn;
	xPosT    wrX;
	objPixT  wrPix;

	objSpriteRam objSpriteRam_i (
		.clk       (clk),
		.cpuSel    (cpuSel),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.scanAddr  (scanAddr),
		.scanData  (scanData)
	);

	// scanBusy already spans the fetcher, so it is the line busy flag
	objLineScanner objLineScanner_i (
		.clk        (clk),
		.rstN       (rstN),
		.lineStart  (lineStart),
		.lineNum    (lineNum),
		.scanAddr   (scanAddr),
		.scanData   (scanData),
		.fetchBusy  (fetchBusy),
		.hitValid   (hitValid),
		.hitTile    (hitTile),
		.hitRow     (hitRow),
		.hitPalette (hitPalette),
		.hitFlip    (hitFlip),
		.hitX       (hitX),
		.scanBusy   (lineBusy)
	);

	objTileFetcher objTileFetcher_i (
		.clk        (clk),
		.rstN       (rstN),
		.hitValid   (hitValid),
		.hitTile    (hitTile),
		.hitRow     (hitRow),
		.hitPalette (hitPalette),
		.hitFlip    (hitFlip),
		.hitX       (hitX),
		.fetchBusy  (fetchBusy),
		.romReq     (romReq),
		.romAddr    (romAddr),
		.romRdy     (romRdy),
		.romData    (romData),
		.wrEn       (wrEn),
		.wrX        (wrX),
		.wrPix      (wrPix)
	);

	objLineBuffer objLineBuffer_i (
		.clk       (clk),
		.rstN      (rstN),
		.lineStart (lineStart),
		.wrEn      (wrEn),
		.wrX       (wrX),
		.wrPix     (wrPix),
		.hPos      (hPos),
		.pixOut    (pixOut)
	);

endmodule

// ==== test/tbClock.sv ====
// Clock and reset source of the testbench
// 10 ns clock, rstN held low for the first 4 rising edges

`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns period
	end

	initial begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;  // Released like any other input
	end

endmodule

// ==== test/objEngine_chk.sv ====
// Assertions bound into the sprite engine top level
// Watch the ROM request handshake and the control outputs coming out of reset

`timescale 1ns/1ps

module objEngine_chk (
	input logic            clk,
	input logic            rstN,
	input logic            romReq,
	input objPkg::romAddrT romAddr,
	input logic            romRdy,
	input logic            lineBusy,
	input logic            fetchBusy,
	input logic            hitValid,
	input logic            wrEn,
	input objPkg::objPixT  pixOut
);

	int failCount = 0;  // Polled by the testbench

	// ----------------------------------------
	// ROM port
	// ----------------------------------------
	// Request and address held until romRdy
	romHold: assert property (@(posedge clk) disable iff (!rstN)
		romReq && !romRdy |=> romReq && $stable(romAddr))
		else begin
			failCount++;
			$error("romReq dropped or romAddr moved before romRdy");
		end

	romInLine: assert property (@(posedge clk) disable iff (!rstN) romReq |-> lineBusy)
		else begin
			failCount++;
			$error("romReq high outside a busy line");
		end

	// Last pixel write still inside the line
	wrInLine: assert property (@(posedge clk) disable iff (!rstN) wrEn |-> lineBusy)
		else begin
			failCount++;
			$error("Line buffer write after lineBusy fell");
		end

	// Everything quiet as reset ends
	resetState: assert property (@(posedge clk) $rose(rstN) |->
		!romReq && !lineBusy && !fetchBusy && !hitValid && !wrEn && pixOut == '0)
		else begin
			failCount++;
			$error("Control outputs not at their reset values");
		end

endmodule

bind objEngine objEngine_chk objEngine_chk_i (
	.clk       (clk),
	.rstN      (rstN),
	.romReq    (romReq),
	.romAddr   (romAddr),
	.romRdy    (romRdy),
	.lineBusy  (lineBusy),
	.fetchBusy (fetchBusy),
	.hitValid  (hitValid),
	.wrEn      (wrEn),
	.pixOut    (pixOut)
);

// ==== test/tbObjEngine.sv ====
// Directed testbench of the sprite engine
// Loads sprites over the CPU port, starts lines, answers ROM requests with random delays
// and compares every displayed line with a reference renderer

`timescale 1ns/1ps
`include "objEngine_defines.svh"

module tbObjEngine;
	import objPkg::*;

	// About 37 lines of under 1500 cycles each plus table loads, three times over
	localparam int LINE_CYCLES = 1500;
	localparam int MAX_LINES   = 40;
	localparam int MAX_CYCLES  = 3 * MAX_LINES * LINE_CYCLES + 20000;
	localparam byteT OFF_Y     = 8'hF0;  // Misses lines 16..239 even at double height

	logic    clk;
	logic    rstN;
	logic    cpuSel;
	logic    cpuWe;
	cpuAddrT cpuAddr;
	byteT    cpuWrData;
	byteT    cpuRdData;
	logic    lineStart;
	lineT    lineNum;
	logic    lineBusy;
	xPosT    hPos;
	objPixT  pixOut;
	logic    romReq;
	romAddrT romAddr;
	logic    romRdy = 1'b0;
	romWordT romData = '0;

	byteT   shadow [`OBJ_COUNT * `OBJ_BYTES];  // Expected attribute RAM
	objPixT expNext [`LINE_PIXELS];            // Line just started
	objPixT expShow [`LINE_PIXELS];            // Line on display
	bit     showValid = 1'b0;                  // Display bank holds a known line
	int     cycles = 0;
	int     romWait = -1;                      // -1 when no request is pending
	logic [31:0] lcgState = 32'd92;

	tbClock tbClock_i (.clk(clk), .rstN(rstN));

	objEngine objEngine_i (
		.clk       (clk),
		.rstN      (rstN),
		.cpuSel    (cpuSel),
		.cpuWe     (cpuWe),
		.cpuAddr   (cpuAddr),
		.cpuWrData (cpuWrData),
		.cpuRdData (cpuRdData),
		.lineStart (lineStart),
		.lineNum   (lineNum),
		.lineBusy  (lineBusy),
		.hPos      (hPos),
		.pixOut    (pixOut),
		.romReq    (romReq),
		.romAddr   (romAddr),
		.romRdy    (romRdy),
		.romData   (romData)
	);

	// ----------------------------------------
	// Helpers
	// ----------------------------------------
	function automatic int nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return int'(lcgState[30:16]);
	endfunction

	// Graphics ROM contents, the top address bit flips the top bit of every nibble
	function automatic romWordT romWordOf(input romAddrT a);
		return romWordT'(a[15:0] ^ 16'h5A5A ^ {4{a[16], 3'b000}});
	endfunction

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic compareByte(input byteT got, input byteT exp, input string name);
		if (got !== exp)
			failRun($sformatf("MISMATCH t=%0t %s got %02h expected %02h", $time, name, got, exp));
	endtask

	task automatic comparePix(input objPixT got, input objPixT exp, input string name);
		if (got !== exp)
			failRun($sformatf("MISMATCH t=%0t %s got %02h expected %02h", $time, name, got, exp));
	endtask

	// Graphics ROM, 0..5 cycles of wait per word
	always @(posedge clk) begin
		#1;
		romRdy = 1'b0;
		if (romReq) begin
			if (romWait < 0) romWait = nextRand() % 6;
			if (romWait == 0) begin
				romRdy  = 1'b1;
				romData = romWordOf(romAddr);
				romWait = -1;
			end else begin
				romWait--;
			end
		end
	end

	// Watchdog, also picks up bound assertion failures
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES)
			failRun($sformatf("Timeout: run still going after %0d cycles", MAX_CYCLES));
		else if (objEngine_i.objEngine_chk_i.failCount != 0)
			failRun("A bound assertion on the sprite engine failed");
	end

	// ----------------------------------------
	// CPU and line tasks
	// ----------------------------------------
	task automatic cpuWrite(input cpuAddrT a, input byteT d);
		cpuSel    = 1'b1;
		cpuWe     = 1'b1;
		cpuAddr   = a;
		cpuWrData = d;
		shadow[a] = d;
		@(posedge clk);
		#1;
		cpuSel = 1'b0;
		cpuWe  = 1'b0;
	endtask

	task automatic cpuRead(input cpuAddrT a, output byteT d);
		cpuSel  = 1'b1;
		cpuWe   = 1'b0;
		cpuAddr = a;
		@(posedge clk);
		#1;
		cpuSel = 1'b0;
		d      = cpuRdData;  // Registered read of the edge just passed
	endtask

	task automatic setSprite(input int idx, input byteT y, input byteT attr,
			input byteT tileLo, input byteT x);
		cpuWrite(cpuAddrT'(idx * 4), y);
		cpuWrite(cpuAddrT'(idx * 4 + 1), attr);
		cpuWrite(cpuAddrT'(idx * 4 + 2), tileLo);
		cpuWrite(cpuAddrT'(idx * 4 + 3), x);
	endtask

	task automatic hideSprites(input int first, input int last);
		for (int e = first; e <= last; e++) cpuWrite(cpuAddrT'(e * 4), OFF_Y);
	endtask

	// Expected line from the rendering rules and the shadow table
	function automatic void renderRef(input lineT ln);
		byteT    y;
		byteT    attr;
		byteT    tileLo;
		byteT    x;
		lineT    row;
		tileNumT tile;
		romWordT w;
		colorT   c;
		xPosT    pos;
		for (int p = 0; p < `LINE_PIXELS; p++) expNext[p] = '0;
		for (int e = 0; e < `OBJ_COUNT; e++) begin
			y      = shadow[e * 4];
			attr   = shadow[e * 4 + 1];
			tileLo = shadow[e * 4 + 2];
			x      = shadow[e * 4 + 3];
			row    = ln - y;  // Mod 256
			if (row >= lineT'(attr[7] ? 32 : 16)) continue;
			tile = {attr[2:0], tileLo};
			if (attr[7]) tile[0] = row[4];  // Lower tile of the pair
			for (int col = 0; col < 16; col++) begin
				w   = romWordOf({tile, 2'(col / 4), row[3:0]});
				c   = w[15 - 4 * (col % 4) -: 4];
				pos = xPosT'(int'(x) + (attr[6] ? 15 - col : col));
				if (c != '0) expNext[pos] = {attr[5:3], c};  // Later entries win
			end
		end
	endfunction

	// Start line ln, check the previous line on display, wait for lineBusy to fall
	task automatic runLine(input lineT ln, input bit keep);
		renderRef(ln);
		lineNum   = ln;
		lineStart = 1'b1;
		hPos      = '0;
		@(posedge clk);
		#1;
		lineStart = 1'b0;
		if (!lineBusy) failRun("lineBusy did not rise the cycle after lineStart");
		for (int i = 0; i < `LINE_PIXELS; i++) begin
			@(posedge clk);
			#1;
			if (showValid) comparePix(pixOut, expShow[i], $sformatf("pixOut at hPos %0d", i));
			hPos = xPosT'(i + 1);
		end
		while (lineBusy) begin
			@(posedge clk);
			#1;
		end
		expShow   = expNext;
		showValid = keep;
	endtask

	// ----------------------------------------
	// Tests
	// ----------------------------------------
	task automatic testCpu();
		cpuAddrT addrs [16];
		byteT    rd;
		for (int i = 0; i < 16; i++) begin
			addrs[i] = cpuAddrT'(nextRand());
			cpuWrite(addrs[i], byteT'(nextRand()));
		end
		compareByte(cpuRdData, 8'hFF, "cpuRdData after a write");
		@(posedge clk);
		#1;
		compareByte(cpuRdData, 8'hFF, "cpuRdData on an idle cycle");
		for (int i = 0; i < 16; i++) begin
			cpuRead(addrs[i], rd);
			compareByte(rd, shadow[addrs[i]], $sformatf("cpuRdData at %03h", addrs[i]));
		end
		@(posedge clk);
		#1;
		compareByte(cpuRdData, 8'hFF, "cpuRdData after the reads");
	endtask

	task automatic testNormal();
		setSprite(5, 8'd60, 8'h1A, 8'h37, 8'd100);
		setSprite(6, 8'd60, 8'h0D, 8'h8C, 8'd250);  // Wraps to 0..9
		runLine(8'd67, 1'b1);
		runLine(8'd75, 1'b1);                       // Last row
		hideSprites(5, 6);
		runLine(8'd75, 1'b1);
	endtask

	task automatic testFlip();
		setSprite(10, 8'd80, 8'h69, 8'hA3, 8'd30);
		runLine(8'd83, 1'b1);
		runLine(8'd90, 1'b1);
		hideSprites(10, 10);
		runLine(8'd90, 1'b1);
	endtask

	task automatic testDouble();
		setSprite(20, 8'd100, 8'h94, 8'h56, 8'd140);
		setSprite(21, 8'd104, 8'hF8, 8'h11, 8'd200);  // Double height and flip
		runLine(8'd105, 1'b1);  // Upper tile
		runLine(8'd121, 1'b1);  // Lower tile
		runLine(8'd131, 1'b1);
		runLine(8'd135, 1'b1);  // Only entry 21 left
		runLine(8'd136, 1'b1);  // Both out of range
		runLine(8'd99, 1'b1);   // Above entry 20
		hideSprites(20, 21);
		runLine(8'd99, 1'b1);
	endtask

	task automatic testOverlap();
		setSprite(30, 8'd150, 8'h1B, 8'h45, 8'd60);
		setSprite(31, 8'd150, 8'h62, 8'h9D, 8'd64);
		setSprite(32, 8'd150, 8'h2C, 8'h31, 8'd66);
		for (int r = 0; r < 16; r++) runLine(lineT'(150 + r), 1'b1);
		hideSprites(30, 32);
		runLine(8'd150, 1'b1);
	endtask

	task automatic testClear();
		for (int e = 0; e < 16; e++) setSprite(40 + e, 8'd200, 8'h08, byteT'(e), byteT'(e * 16));
		runLine(8'd205, 1'b1);  // Full line of pixels
		hideSprites(40, 55);
		runLine(8'd205, 1'b1);
		runLine(8'd205, 1'b1);
		runLine(8'd205, 1'b1);  // Reuses the bank that held the full line
		runLine(8'd205, 1'b1);
	endtask

	initial begin
		cpuSel    = 1'b0;
		cpuWe     = 1'b0;
		cpuAddr   = '0;
		cpuWrData = '0;
		lineStart = 1'b0;
		lineNum   = '0;
		hPos      = '0;
		@(posedge rstN);
		@(posedge clk);
		#1;
		testCpu();
		for (int e = 0; e < `OBJ_COUNT; e++) setSprite(e, OFF_Y, 8'h00, 8'h00, 8'h00);
		// Warm-up, the first write bank still holds unknown pixels
		runLine(8'd20, 1'b0);
		runLine(8'd20, 1'b1);
		testNormal();
		testFlip();
		testDouble();
		testOverlap();
		testClear();
		if (objEngine_i.objEngine_chk_i.failCount == 0) begin
			$display("All tests passed!");
		end else begin
			failRun("A bound assertion on the sprite engine failed");
		end
		$finish;
	end

endmodule

// ==== compile.f ====
+incdir+logic
logic/objPkg.sv
logic/objSpriteRam.sv
logic/objLineScanner.sv
logic/objTileFetcher.sv
logic/objLineBuffer.sv
logic/objEngine.sv
test/tbClock.sv
test/objEngine_chk.sv
test/tbObjEngine.sv

// ==== run.sh ====
#!/bin/sh
# Builds the sprite engine testbench with Verilator and runs it
set -e

verilator --binary --timing --assert -f compile.f --top-module tbObjEngine -Mdir obj_dir

out=$(./obj_dir/VtbObjEngine 2>&1) || true
echo "$out"
echo "$out" | grep -q "All tests passed!"
